//--- hw/sb_pkg.sv
package sb_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  localparam int unsigned XLEN      = 64;
  localparam int unsigned SB_DEPTH  = 4;                 // Store buffer entries
  localparam int unsigned SB_IDX_W  = $clog2(SB_DEPTH);
  localparam int unsigned ROB_IDX_W = 4;
  localparam int unsigned BE_W      = XLEN / 8;          // One enable per byte

  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [SB_IDX_W-1:0]  sb_idx_t;

  // Store width, as encoded by the decoder
  typedef enum logic [1:0] {
    LS_BYTE,
    LS_HALF,
    LS_WORD,
    LS_DOUBLE
  } ls_width_t;

  // Life of one entry
  typedef enum logic [3:0] {
    S_EMPTY,
    S_RS12_PENDING,  // Base and data both missing
    S_RS1_PENDING,
    S_RS2_PENDING,
    S_ADDR_REQ,
    S_ADDR_WAIT,
    S_WAIT_ROB,      // Address known, not yet committed
    S_MEM_REQ,
    S_MEM_WAIT,
    S_COMPLETED
  } sb_state_t;

  // --------------------------------------------------------------------------
  // Port and storage structs
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic            ready;
    rob_idx_t        rob_idx;  // Producer tag when not ready
    logic [XLEN-1:0] value;
  } operand_t;

  typedef struct packed {
    ls_width_t       width;
    operand_t        rs1;      // Base address
    operand_t        rs2;      // Store data
    logic [XLEN-1:0] imm;
    rob_idx_t        dest;
  } issue_t;

  typedef struct packed {
    rob_idx_t        rob_idx;
    logic [XLEN-1:0] value;
  } cdb_t;

  typedef struct packed {
    ls_width_t       width;
    rob_idx_t        rs1_rob_idx;
    logic [XLEN-1:0] rs1_value;
    rob_idx_t        rs2_rob_idx;
    logic [XLEN-1:0] rs2_value;
    rob_idx_t        dest_rob_idx;
    logic [XLEN-1:0] imm_addr;   // Offset first, address once the adder answers
    logic            committed;
  } sb_data_t;

  typedef struct packed {
    sb_idx_t         tag;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] offs;
  } adder_req_t;

  typedef struct packed {
    sb_idx_t         tag;
    logic [XLEN-1:0] result;
  } adder_ans_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wdata;
    sb_idx_t         tag;
  } mem_req_t;

endpackage

//--- hw/sb_entry.sv
module sb_entry import sb_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  input  logic            push_i,
  input  issue_t          issue_i,
  input  logic            cdb_valid_i,
  input  cdb_t            cdb_i,
  input  logic            addr_sent_i,
  input  logic            addr_done_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic            commit_i,
  input  logic            mem_sent_i,
  input  logic            mem_done_i,
  input  logic            pop_i,
  output sb_state_t       state_o,
  output sb_data_t        data_o
);

  sb_state_t state_q, state_d;
  sb_data_t  data_q;
  logic      wait_rs1, wait_rs2;
  logic      hit_rs1, hit_rs2;
  logic      committed;

  assign wait_rs1 = (state_q == S_RS12_PENDING) || (state_q == S_RS1_PENDING);
  assign wait_rs2 = (state_q == S_RS12_PENDING) || (state_q == S_RS2_PENDING);

  // Tag match only while the operand is still missing
  assign hit_rs1 = cdb_valid_i && wait_rs1 && (cdb_i.rob_idx == data_q.rs1_rob_idx);
  assign hit_rs2 = cdb_valid_i && wait_rs2 && (cdb_i.rob_idx == data_q.rs2_rob_idx);

  assign committed = data_q.committed || commit_i;  // Pulse may meet the answer

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_EMPTY: begin
        if (push_i) begin
          case ({issue_i.rs1.ready, issue_i.rs2.ready})
            2'b11:   state_d = S_ADDR_REQ;
            2'b01:   state_d = S_RS1_PENDING;
            2'b10:   state_d = S_RS2_PENDING;
            default: state_d = S_RS12_PENDING;
          endcase
        end
      end
      S_RS12_PENDING: begin
        if (hit_rs1 && hit_rs2) begin
          state_d = S_ADDR_REQ;  // Same producer for both
        end else if (hit_rs1) begin
          state_d = S_RS2_PENDING;
        end else if (hit_rs2) begin
          state_d = S_RS1_PENDING;
        end
      end
      S_RS1_PENDING: if (hit_rs1) state_d = S_ADDR_REQ;
      S_RS2_PENDING: if (hit_rs2) state_d = S_ADDR_REQ;
      S_ADDR_REQ, S_ADDR_WAIT: begin
        // A zero-latency adder answers in the request cycle
        if (addr_done_i) begin
          state_d = committed ? S_MEM_REQ : S_WAIT_ROB;
        end else if (addr_sent_i) begin
          state_d = S_ADDR_WAIT;
        end
      end
      S_WAIT_ROB: if (commit_i) state_d = S_MEM_REQ;
      S_MEM_REQ, S_MEM_WAIT: begin
        if (mem_done_i) begin
          state_d = S_COMPLETED;
        end else if (mem_sent_i) begin
          state_d = S_MEM_WAIT;
        end
      end
      S_COMPLETED: if (pop_i) state_d = S_EMPTY;
      default: state_d = S_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_EMPTY;
    end else if (flush_i) begin
      state_q <= S_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------------------------------
  // Entry fields
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q <= '0;
    end else if (push_i) begin
      data_q.width        <= issue_i.width;
      data_q.rs1_rob_idx  <= issue_i.rs1.rob_idx;
      data_q.rs1_value    <= issue_i.rs1.value;
      data_q.rs2_rob_idx  <= issue_i.rs2.rob_idx;
      data_q.rs2_value    <= issue_i.rs2.value;
      data_q.dest_rob_idx <= issue_i.dest;
      data_q.imm_addr     <= issue_i.imm;
      data_q.committed    <= 1'b0;
    end else begin
      if (hit_rs1) data_q.rs1_value <= cdb_i.value;
      if (hit_rs2) data_q.rs2_value <= cdb_i.value;
      if (addr_done_i) data_q.imm_addr <= addr_i;  // Offset no longer needed
      if (commit_i && state_q != S_EMPTY) data_q.committed <= 1'b1;
    end
  end

  assign state_o = state_q;
  assign data_o  = data_q;

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {S_EMPTY, S_RS12_PENDING, S_RS1_PENDING, S_RS2_PENDING,
                    S_ADDR_REQ, S_ADDR_WAIT, S_WAIT_ROB, S_MEM_REQ, S_MEM_WAIT,
                    S_COMPLETED});

  // Tail decode must never land on a busy slot
  a_push_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> state_q == S_EMPTY);

endmodule

//--- hw/sb_queue_ptrs.sv
module sb_queue_ptrs import sb_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    flush_i,
  input  logic    push_i,
  input  logic    addr_sent_i,
  input  logic    mem_sent_i,
  input  logic    pop_i,
  output sb_idx_t tail_o,
  output sb_idx_t addr_o,
  output sb_idx_t mem_o,
  output sb_idx_t head_o,
  output logic    full_o
);

  logic [SB_IDX_W:0] count_q;  // Occupied entries

  function automatic sb_idx_t ptr_inc(sb_idx_t ptr);
    return (ptr == sb_idx_t'(SB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tail_o  <= '0;
      addr_o  <= '0;
      mem_o   <= '0;
      head_o  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      tail_o  <= '0;
      addr_o  <= '0;
      mem_o   <= '0;
      head_o  <= '0;
      count_q <= '0;
    end else begin
      if (push_i)      tail_o <= ptr_inc(tail_o);
      if (addr_sent_i) addr_o <= ptr_inc(addr_o);
      if (mem_sent_i)  mem_o  <= ptr_inc(mem_o);
      if (pop_i)       head_o <= ptr_inc(head_o);
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  // Tail slot is busy exactly when every entry is occupied
  assign full_o = (count_q == (SB_IDX_W + 1)'(SB_DEPTH));

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> count_q != '0);

endmodule

//--- hw/sb_mem_req.sv
module sb_mem_req import sb_pkg::*; (
  input  sb_data_t  [SB_DEPTH-1:0] entries_i,
  input  sb_state_t [SB_DEPTH-1:0] states_i,
  input  sb_idx_t                  mem_idx_i,
  output logic                     mem_valid_o,
  output mem_req_t                 mem_req_o,
  output rob_idx_t                 comm_rob_idx_o
);

  sb_data_t sel;

  assign sel = entries_i[mem_idx_i];

  assign mem_valid_o    = (states_i[mem_idx_i] == S_MEM_REQ);
  assign comm_rob_idx_o = sel.dest_rob_idx;  // Oldest store not yet sent

  // --------------------------------------------------------------------------
  // Request payload
  // --------------------------------------------------------------------------
  always_comb begin
    mem_req_o.addr  = sel.imm_addr;
    mem_req_o.wdata = sel.rs2_value;  // Memory picks the low bytes
    mem_req_o.tag   = mem_idx_i;
    case (sel.width)
      LS_BYTE:   mem_req_o.be = BE_W'(8'b0000_0001);
      LS_HALF:   mem_req_o.be = BE_W'(8'b0000_0011);
      LS_WORD:   mem_req_o.be = BE_W'(8'b0000_1111);
      LS_DOUBLE: mem_req_o.be = '1;
      default:   mem_req_o.be = '0;
    endcase
  end

endmodule

//--- hw/store_buffer.sv
module store_buffer import sb_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  // Issue stage
  input  logic       issue_valid_i,
  output logic       issue_ready_o,
  input  issue_t     issue_i,
  // Common data bus
  input  logic       cdb_valid_i,
  input  cdb_t       cdb_i,
  output logic       cdb_valid_o,
  input  logic       cdb_ready_i,
  output cdb_t       cdb_o,
  // Address adder
  output logic       adder_valid_o,
  input  logic       adder_ready_i,
  output adder_req_t adder_req_o,
  input  logic       adder_valid_i,
  input  adder_ans_t adder_ans_i,
  // Commit
  output rob_idx_t   comm_mem_idx_o,
  input  logic       comm_mem_clear_i,
  // Memory
  output logic       mem_valid_o,
  input  logic       mem_ready_i,
  output mem_req_t   mem_req_o,
  input  logic       mem_valid_i,
  input  sb_idx_t    mem_tag_i
);

  sb_idx_t tail_idx, addr_idx, mem_idx, head_idx;
  logic    full;
  logic    push, addr_sent, mem_sent, pop;

  logic [SB_DEPTH-1:0] push_oh, addr_sent_oh, addr_done_oh;
  logic [SB_DEPTH-1:0] commit_oh, mem_sent_oh, mem_done_oh, pop_oh;

  sb_state_t [SB_DEPTH-1:0] states;
  sb_data_t  [SB_DEPTH-1:0] entries;

  // --------------------------------------------------------------------------
  // Handshakes and per-entry strobes
  // --------------------------------------------------------------------------
  assign push      = issue_valid_i && issue_ready_o;
  assign addr_sent = adder_valid_o && adder_ready_i;
  assign mem_sent  = mem_valid_o && mem_ready_i;
  assign pop       = cdb_valid_o && cdb_ready_i;

  always_comb begin
    for (int i = 0; i < SB_DEPTH; i++) begin
      push_oh[i]      = push && (tail_idx == sb_idx_t'(i));
      addr_sent_oh[i] = addr_sent && (addr_idx == sb_idx_t'(i));
      addr_done_oh[i] = adder_valid_i && (adder_ans_i.tag == sb_idx_t'(i));
      commit_oh[i]    = comm_mem_clear_i && (mem_idx == sb_idx_t'(i));
      mem_sent_oh[i]  = mem_sent && (mem_idx == sb_idx_t'(i));
      mem_done_oh[i]  = mem_valid_i && (mem_tag_i == sb_idx_t'(i));
      pop_oh[i]       = pop && (head_idx == sb_idx_t'(i));
    end
  end

  sb_queue_ptrs u_ptrs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .push_i     (push),
    .addr_sent_i(addr_sent),
    .mem_sent_i (mem_sent),
    .pop_i      (pop),
    .tail_o     (tail_idx),
    .addr_o     (addr_idx),
    .mem_o      (mem_idx),
    .head_o     (head_idx),
    .full_o     (full)
  );

  for (genvar i = 0; i < SB_DEPTH; i++) begin : gen_entry
    sb_entry u_entry (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .flush_i    (flush_i),
      .push_i     (push_oh[i]),
      .issue_i    (issue_i),
      .cdb_valid_i(cdb_valid_i),
      .cdb_i      (cdb_i),
      .addr_sent_i(addr_sent_oh[i]),
      .addr_done_i(addr_done_oh[i]),
      .addr_i     (adder_ans_i.result),
      .commit_i   (commit_oh[i]),
      .mem_sent_i (mem_sent_oh[i]),
      .mem_done_i (mem_done_oh[i]),
      .pop_i      (pop_oh[i]),
      .state_o    (states[i]),
      .data_o     (entries[i])
    );
  end

  sb_mem_req u_mem_req (
    .entries_i     (entries),
    .states_i      (states),
    .mem_idx_i     (mem_idx),
    .mem_valid_o   (mem_valid_o),
    .mem_req_o     (mem_req_o),
    .comm_rob_idx_o(comm_mem_idx_o)
  );

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------
  assign issue_ready_o = !full;

  assign adder_valid_o = (states[addr_idx] == S_ADDR_REQ);
  assign adder_req_o   = '{tag:  addr_idx,
                           base: entries[addr_idx].rs1_value,
                           offs: entries[addr_idx].imm_addr};

  // Address goes out as the result
  assign cdb_valid_o = (states[head_idx] == S_COMPLETED);
  assign cdb_o       = '{rob_idx: entries[head_idx].dest_rob_idx,
                         value:   entries[head_idx].imm_addr};

endmodule

//--- sim/tb_store_buffer.sv
module tb_store_buffer import sb_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS        = 6;
  localparam int WATCHDOG_CYCLES = (NUM_ROWS + SB_DEPTH) * 200;

  logic       clk_i = 1'b0;
  logic       rst_ni, flush_i;
  logic       issue_valid_i, issue_ready_o;
  issue_t     issue_i;
  logic       cdb_valid_i, cdb_valid_o, cdb_ready_i;
  cdb_t       cdb_i, cdb_o;
  logic       adder_valid_o, adder_ready_i, adder_valid_i;
  adder_req_t adder_req_o;
  adder_ans_t adder_ans_i;
  rob_idx_t   comm_mem_idx_o;
  logic       comm_mem_clear_i;
  logic       mem_valid_o, mem_ready_i, mem_valid_i;
  mem_req_t   mem_req_o;
  sb_idx_t    mem_tag_i;

  issue_t     stim[$];      // Stimulus table, one store per row
  cdb_t       bcast_q[$];   // Operands still to broadcast
  adder_ans_t add_q[$];
  sb_idx_t    mem_q[$];
  logic       models_on = 1'b0;
  int         issue_cnt = 0;
  int         add_cnt = 0;
  int         mem_cnt = 0;
  int         commit_cnt = 0;
  int         wb_cnt = 0;
  int         add_limit = NUM_ROWS;  // Stores the adder may still accept
  int         mem_limit = NUM_ROWS;
  int         wb_limit = NUM_ROWS;

  always #10 clk_i = ~clk_i;

  store_buffer uut (.*);

  // --------------------------------------------------------------------------
  // Expected values and compare tasks
  // --------------------------------------------------------------------------
  function automatic issue_t make_row(ls_width_t w, logic r1_rdy, rob_idx_t r1_tag,
                                      logic [XLEN-1:0] r1_val, logic r2_rdy,
                                      rob_idx_t r2_tag, logic [XLEN-1:0] r2_val,
                                      logic [XLEN-1:0] imm, rob_idx_t dest);
    issue_t r;
    r.width       = w;
    r.rs1.ready   = r1_rdy;
    r.rs1.rob_idx = r1_tag;
    r.rs1.value   = r1_val;
    r.rs2.ready   = r2_rdy;
    r.rs2.rob_idx = r2_tag;
    r.rs2.value   = r2_val;
    r.imm         = imm;
    r.dest        = dest;
    return r;
  endfunction

  function automatic logic [BE_W-1:0] width_to_be(ls_width_t w);
    case (w)
      LS_BYTE: return 8'h01;
      LS_HALF: return 8'h03;
      LS_WORD: return 8'h0f;
      default: return 8'hff;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] store_addr(int k);
    return stim[k].rs1.value + stim[k].imm;
  endfunction

  task automatic stop_run(string why);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_adder(adder_req_t got, adder_req_t exp);
    if (got !== exp) begin
      $display("MISMATCH @%0t: adder request %h, expected %h", $time, got, exp);
      stop_run("adder request differs from the model");
    end
  endtask

  task automatic check_mem(mem_req_t got, mem_req_t exp);
    if (got !== exp) begin
      $display("MISMATCH @%0t: memory request %h, expected %h", $time, got, exp);
      stop_run("memory request differs from the model");
    end
  endtask

  task automatic check_cdb(cdb_t got, cdb_t exp);
    if (got !== exp) begin
      $display("MISMATCH @%0t: CDB output %h, expected %h", $time, got, exp);
      stop_run("CDB writeback differs from the model");
    end
  endtask

  task automatic check_rob(rob_idx_t got, rob_idx_t exp);
    if (got !== exp) begin
      $display("MISMATCH @%0t: commit index %0d, expected %0d", $time, got, exp);
      stop_run("commit index differs from the model");
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH @%0t: %s is %b, expected %b", $time, name, got, exp);
      stop_run("control flag differs from the model");
    end
  endtask

  // --------------------------------------------------------------------------
  // ROB, CDB producer, adder and memory models
  // --------------------------------------------------------------------------
  task automatic observe_edge();
    issue_t     row;
    cdb_t       bc;
    adder_req_t exp_add;
    adder_ans_t ans;
    mem_req_t   exp_mem;
    if (mem_cnt < issue_cnt) check_rob(comm_mem_idx_o, stim[mem_cnt].dest);
    if (cdb_valid_i) void'(bcast_q.pop_front());
    if (issue_valid_i && issue_ready_o) begin
      row = stim[issue_cnt];
      if (!row.rs1.ready) begin
        bc = '{rob_idx: row.rs1.rob_idx, value: row.rs1.value};
        bcast_q.push_back(bc);
      end
      // One broadcast serves both operands of a shared producer
      if (!row.rs2.ready && (row.rs1.ready || row.rs1.rob_idx != row.rs2.rob_idx)) begin
        bc = '{rob_idx: row.rs2.rob_idx, value: row.rs2.value};
        bcast_q.push_back(bc);
      end
      issue_cnt++;
    end
    if (adder_valid_i) void'(add_q.pop_front());
    if (adder_valid_o) begin
      exp_add.tag  = sb_idx_t'(add_cnt % SB_DEPTH);
      exp_add.base = stim[add_cnt].rs1.value;
      exp_add.offs = stim[add_cnt].imm;
      check_adder(adder_req_o, exp_add);
      if (adder_ready_i) begin
        ans.tag    = exp_add.tag;
        ans.result = exp_add.base + exp_add.offs;
        add_q.push_back(ans);
        add_cnt++;
      end
    end
    if (mem_valid_i) void'(mem_q.pop_front());
    if (mem_valid_o) begin
      if (mem_cnt >= commit_cnt) stop_run("memory request raised before its commit pulse");
      exp_mem.addr  = store_addr(mem_cnt);
      exp_mem.be    = width_to_be(stim[mem_cnt].width);
      exp_mem.wdata = stim[mem_cnt].rs2.value;
      exp_mem.tag   = sb_idx_t'(mem_cnt % SB_DEPTH);
      check_mem(mem_req_o, exp_mem);
      if (mem_ready_i) begin
        mem_q.push_back(exp_mem.tag);
        mem_cnt++;
      end
    end
    if (comm_mem_clear_i) commit_cnt++;
    if (cdb_valid_o) begin
      bc = '{rob_idx: stim[wb_cnt].dest, value: store_addr(wb_cnt)};
      check_cdb(cdb_o, bc);  // Checked every valid cycle, so a stall must hold it
      if (cdb_ready_i) wb_cnt++;
    end
  endtask

  task automatic drive_models();
    if (models_on) begin
      cdb_valid_i = (bcast_q.size() != 0) && (($urandom % 3) != 0);
      if (cdb_valid_i) cdb_i = bcast_q[0];
      adder_ready_i = (add_cnt < add_limit) && (($urandom % 4) != 0);
      adder_valid_i = (add_q.size() != 0) && (($urandom % 3) == 0);
      if (adder_valid_i) adder_ans_i = add_q[0];
      mem_ready_i = (mem_cnt < mem_limit) && (($urandom % 4) != 0);
      mem_valid_i = (mem_q.size() != 0) && (($urandom % 2) == 0);
      if (mem_valid_i) mem_tag_i = mem_q[0];
      cdb_ready_i = (wb_cnt < wb_limit) && (($urandom % 3) != 0);
      // Commit only the oldest store, once it is in the buffer
      comm_mem_clear_i = (commit_cnt == mem_cnt) && (commit_cnt < issue_cnt) &&
                         (($urandom % 4) == 0);
    end else begin
      cdb_valid_i      = 1'b0;
      adder_ready_i    = 1'b0;
      adder_valid_i    = 1'b0;
      mem_ready_i      = 1'b0;
      mem_valid_i      = 1'b0;
      cdb_ready_i      = 1'b0;
      comm_mem_clear_i = 1'b0;
    end
  endtask

  initial begin
    cdb_valid_i      = 1'b0;
    cdb_i            = '0;
    adder_ready_i    = 1'b0;
    adder_valid_i    = 1'b0;
    adder_ans_i      = '0;
    comm_mem_clear_i = 1'b0;
    mem_ready_i      = 1'b0;
    mem_valid_i      = 1'b0;
    mem_tag_i        = '0;
    cdb_ready_i      = 1'b0;
    forever begin
      @(posedge clk_i);
      if (models_on) observe_edge();
      #2;
      drive_models();
    end
  end

  // --------------------------------------------------------------------------
  // Issue sequence
  // --------------------------------------------------------------------------
  task automatic issue_row(issue_t row);
    issue_t drv;
    drv = row;
    if (!row.rs1.ready) drv.rs1.value = ~row.rs1.value;  // Stale register file value
    if (!row.rs2.ready) drv.rs2.value = ~row.rs2.value;
    @(posedge clk_i);
    #2;
    issue_i       = drv;
    issue_valid_i = 1'b1;
    do @(posedge clk_i); while (!issue_ready_o);
    #2;
    issue_valid_i = 1'b0;
  endtask

  initial begin
    void'($urandom(32'hbb15_936a));
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    stim.push_back(make_row(LS_DOUBLE, 1'b1, 4'd0, 64'h0000_0000_8000_0000,
                            1'b1, 4'd0, 64'h0123_4567_89ab_cdef, 64'h10, 4'd1));
    stim.push_back(make_row(LS_WORD, 1'b0, 4'd8, 64'h0000_0000_8000_1000,
                            1'b1, 4'd0, 64'hdead_beef_cafe_f00d, 64'h8, 4'd2));
    stim.push_back(make_row(LS_HALF, 1'b1, 4'd0, 64'h0000_0001_0000_0000,
                            1'b0, 4'd9, 64'h0000_0000_0000_1234, 64'hffff_ffff_ffff_fffe, 4'd3));
    stim.push_back(make_row(LS_BYTE, 1'b0, 4'd10, 64'h0000_0000_0004_0000,
                            1'b0, 4'd11, 64'h0000_0000_0000_00a5, 64'h3, 4'd4));
    stim.push_back(make_row(LS_WORD, 1'b0, 4'd12, 64'h0000_0000_0000_2000,
                            1'b0, 4'd12, 64'h0000_0000_0000_2000, 64'h40, 4'd5));
    stim.push_back(make_row(LS_DOUBLE, 1'b1, 4'd0, 64'h0000_7fff_0000_0000,
                            1'b1, 4'd0, 64'hfedc_ba98_7654_3210, 64'h100, 4'd6));
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("issue_ready_o after reset", issue_ready_o, 1'b1);
    check_flag("cdb_valid_o after reset", cdb_valid_o, 1'b0);
    check_flag("adder_valid_o after reset", adder_valid_o, 1'b0);
    check_flag("mem_valid_o after reset", mem_valid_o, 1'b0);

    // All stores through the full pipeline with random stalls
    models_on = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) issue_row(stim[r]);
    while (wb_cnt < NUM_ROWS) @(negedge clk_i);
    check_flag("cdb_valid_o once drained", cdb_valid_o, 1'b0);

    // Stalled writeback fills the buffer before a flush clears it
    for (int r = 0; r < SB_DEPTH; r++) stim.push_back(stim[r]);
    add_limit = NUM_ROWS + 2;
    mem_limit = NUM_ROWS + 1;
    wb_limit  = NUM_ROWS;
    for (int r = NUM_ROWS; r < NUM_ROWS + SB_DEPTH; r++) issue_row(stim[r]);
    @(negedge clk_i);
    check_flag("issue_ready_o when full", issue_ready_o, 1'b0);
    // One store held in each of the writeback, memory and address phases
    while (!(cdb_valid_o && mem_valid_o && adder_valid_o)) @(negedge clk_i);
    models_on = 1'b0;
    @(posedge clk_i);
    #2;
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    @(negedge clk_i);
    check_flag("issue_ready_o after flush", issue_ready_o, 1'b1);
    check_flag("cdb_valid_o after flush", cdb_valid_o, 1'b0);
    check_flag("adder_valid_o after flush", adder_valid_o, 1'b0);
    check_flag("mem_valid_o after flush", mem_valid_o, 1'b0);
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("TESTBENCH FAILED");
    $fatal(1, "Timeout: the stores did not finish within %0d cycles", WATCHDOG_CYCLES);
  end

endmodule

//--- filelist.f
hw/sb_pkg.sv
hw/sb_entry.sv
hw/sb_queue_ptrs.sv
hw/sb_mem_req.sv
hw/store_buffer.sv
sim/tb_store_buffer.sv

//--- Makefile
TOP := tb_store_buffer

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f filelist.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
